// ==== cpu_top.f ====
src/cpu_pkg.sv
src/pc_counter.sv
src/fetch_unit.sv
src/inst_queue.sv
src/decode_unit.sv
src/reg_file.sv
src/execute_unit.sv
src/cpu_top.sv
verif/tb_cpu_top.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

LOG=sim.log

rm -rf obj_dir
verilator --binary --timing --assert \
    --top-module tb_cpu_top \
    -f cpu_top.f \
    -o sim_cpu

./obj_dir/sim_cpu > "$LOG" 2>&1 || true
cat "$LOG"

if grep -q "sim failed" "$LOG"; then
    echo "simulation FAILED, see $LOG"
    exit 1
fi
if ! grep -q "sim passed" "$LOG"; then
    echo "no pass report found in $LOG"
    exit 1
fi
echo "simulation PASSED"

// ==== src/cpu_pkg.sv ====
package cpu_pkg;

    localparam int WORD        = 32;
    localparam int ADDR        = 16;
    localparam int N_REG       = 16;
    localparam int W_RD        = 4;
    localparam int W_IMM       = 18;
    localparam int QUEUE_DEPTH = 4;

    // zero is not a valid opcode, so an empty word runs as a no-op.
    typedef enum logic [5:0] {
        OP_ADD  = 6'h01,
        OP_SUB  = 6'h02,
        OP_AND  = 6'h03,
        OP_OR   = 6'h04,
        OP_XOR  = 6'h05,
        OP_ADDI = 6'h06,
        OP_LD   = 6'h07,
        OP_ST   = 6'h08,
        OP_BEQ  = 6'h09,
        OP_JMP  = 6'h0a,
        OP_HLT  = 6'h0b
    } opcode_e;

    typedef enum logic [2:0] {
        ALU_ADD  = 3'd0,
        ALU_SUB  = 3'd1,
        ALU_AND  = 3'd2,
        ALU_OR   = 3'd3,
        ALU_XOR  = 3'd4,
        ALU_PASS = 3'd5
    } alu_op_e;

    typedef struct packed {
        opcode_e           opcode;
        logic [W_RD-1:0]   rd;
        logic [W_RD-1:0]   rs0;
        logic [W_RD-1:0]   rs1;
        logic [13:0]       unused;
    } inst_r_t;

    // st and beq carry their second source register in rd.
    typedef struct packed {
        opcode_e           opcode;
        logic [W_RD-1:0]   rd;
        logic [W_RD-1:0]   rs0;
        logic [W_IMM-1:0]  imm;
    } inst_i_t;

    typedef union packed {
        inst_r_t r;
        inst_i_t i;
    } inst_u;

    // instructions that write rd back to the register file.
    function automatic logic writes_reg(input opcode_e op);
        return op inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_ADDI, OP_LD};
    endfunction

endpackage

// ==== src/cpu_top.sv ====
`timescale 1ns/100ps

module cpu_top import cpu_pkg::*; #(
    parameter int WORD_W = WORD,
    parameter int ADDR_W = ADDR,
    parameter int REG_N  = N_REG,
    parameter int RD_W   = W_RD,
    parameter int IMM_W  = W_IMM,
    parameter int DEPTH  = QUEUE_DEPTH
) (
    input  logic              clk,
    input  logic              rst_n_i,
    input  logic              stall_i,
    input  logic [WORD_W-1:0] inst_i,
    output logic [ADDR_W-1:0] inst_addr_o,
    input  logic [WORD_W-1:0] ldst_data_i,
    output logic [WORD_W-1:0] ldst_data_o,
    output logic [ADDR_W-1:0] ldst_addr_o,
    output logic              ldst_write_o,
    output logic              hlt_o
);
    // flush
    logic              branch;
    logic [ADDR_W-1:0] branch_addr;

    // pc and fetch
    logic [ADDR_W-1:0] pc_pf;
    logic              stall_fp;

    // fetch to queue
    logic              v_fq, stall_qf;
    logic [WORD_W-1:0] inst_fq;
    logic [ADDR_W-1:0] pc_fq;

    // queue to decode
    logic              v_qd, stall_dq;
    logic [WORD_W-1:0] inst_qd;
    logic [ADDR_W-1:0] pc_qd;

    // decode and register file
    logic [RD_W-1:0]   r0_dr, r1_dr, reserve_r_dr;
    logic [WORD_W-1:0] r_opr0_rd, r_opr1_rd;
    logic [1:0]        reserved_rd;
    logic              w_reserve_dr;

    // decode to execute
    logic              v_de, stall_ed;
    logic [ADDR_W-1:0] pc_de;
    logic [WORD_W-1:0] opr0_de, opr1_de, imm_de;
    alu_op_e           alu_op_de;
    opcode_e           opcode_de;
    logic [RD_W-1:0]   wb_r_de;

    // write-back
    logic              wb_er;
    logic [RD_W-1:0]   wb_r_er;
    logic [WORD_W-1:0] result_er;

    assign inst_addr_o = pc_pf;

    pc_counter #(.ADDR_W(ADDR_W)) pc (
        .clk(clk), .rst_n_i(rst_n_i),
        .stall_i(stall_fp), .branch_i(branch), .branch_addr_i(branch_addr),
        .pc_o(pc_pf)
    );

    fetch_unit #(.WORD_W(WORD_W), .ADDR_W(ADDR_W)) fetch (
        .clk(clk), .rst_n_i(rst_n_i),
        .stall_i(stall_qf), .branch_i(branch),
        .inst_i(inst_i), .pc_i(pc_pf),
        .v_o(v_fq), .inst_o(inst_fq), .pc_o(pc_fq), .stall_o(stall_fp)
    );

    inst_queue #(.WORD_W(WORD_W), .ADDR_W(ADDR_W), .DEPTH(DEPTH)) queue (
        .clk(clk), .rst_n_i(rst_n_i),
        .v_i(v_fq), .stall_i(stall_dq), .branch_i(branch),
        .inst_i(inst_fq), .pc_i(pc_fq),
        .v_o(v_qd), .stall_o(stall_qf), .inst_o(inst_qd), .pc_o(pc_qd)
    );

    decode_unit #(.WORD_W(WORD_W), .ADDR_W(ADDR_W), .RD_W(RD_W), .IMM_W(IMM_W)) decode (
        .clk(clk), .rst_n_i(rst_n_i),
        .v_i(v_qd), .stall_i(stall_ed), .branch_i(branch),
        .inst_i(inst_qd), .pc_i(pc_qd),
        .r0_o(r0_dr), .r1_o(r1_dr),
        .r_opr0_i(r_opr0_rd), .r_opr1_i(r_opr1_rd), .reserved_i(reserved_rd),
        .w_reserve_o(w_reserve_dr), .reserve_r_o(reserve_r_dr),
        .stall_o(stall_dq), .v_o(v_de), .pc_o(pc_de),
        .opr0_o(opr0_de), .opr1_o(opr1_de), .imm_o(imm_de),
        .alu_op_o(alu_op_de), .opcode_o(opcode_de), .wb_r_o(wb_r_de)
    );

    reg_file #(.WORD_W(WORD_W), .REG_N(REG_N), .RD_W(RD_W)) regs (
        .clk(clk), .rst_n_i(rst_n_i),
        .r0_i(r0_dr), .r1_i(r1_dr),
        .r_opr0_o(r_opr0_rd), .r_opr1_o(r_opr1_rd), .reserved_o(reserved_rd),
        .w_reserve_i(w_reserve_dr), .reserve_r_i(reserve_r_dr),
        .wb_i(wb_er), .wb_r_i(wb_r_er), .result_i(result_er)
    );

    execute_unit #(.WORD_W(WORD_W), .ADDR_W(ADDR_W), .RD_W(RD_W)) exec (
        .clk(clk), .rst_n_i(rst_n_i),
        .v_i(v_de), .stall_i(stall_i), .pc_i(pc_de),
        .opr0_i(opr0_de), .opr1_i(opr1_de), .imm_i(imm_de),
        .alu_op_i(alu_op_de), .opcode_i(opcode_de), .wb_r_i(wb_r_de),
        .stall_o(stall_ed),
        .ldst_addr_o(ldst_addr_o), .ldst_write_o(ldst_write_o),
        .ldst_data_o(ldst_data_o), .ldst_data_i(ldst_data_i),
        .wb_o(wb_er), .wb_r_o(wb_r_er), .result_o(result_er),
        .branch_o(branch), .branch_addr_o(branch_addr),
        .hlt_o(hlt_o)
    );

endmodule

// ==== src/decode_unit.sv ====
`timescale 1ns/100ps

module decode_unit import cpu_pkg::*; #(
    parameter int WORD_W = WORD,
    parameter int ADDR_W = ADDR,
    parameter int RD_W   = W_RD,
    parameter int IMM_W  = W_IMM
) (
    input  logic              clk,
    input  logic              rst_n_i,
    input  logic              v_i,
    input  logic              stall_i,
    input  logic              branch_i,
    input  logic [WORD_W-1:0] inst_i,
    input  logic [ADDR_W-1:0] pc_i,
    output logic [RD_W-1:0]   r0_o,
    output logic [RD_W-1:0]   r1_o,
    input  logic [WORD_W-1:0] r_opr0_i,
    input  logic [WORD_W-1:0] r_opr1_i,
    input  logic [1:0]        reserved_i,
    output logic              w_reserve_o,
    output logic [RD_W-1:0]   reserve_r_o,
    output logic              stall_o,
    output logic              v_o,
    output logic [ADDR_W-1:0] pc_o,
    output logic [WORD_W-1:0] opr0_o,
    output logic [WORD_W-1:0] opr1_o,
    output logic [WORD_W-1:0] imm_o,
    output alu_op_e           alu_op_o,
    output opcode_e           opcode_o,
    output logic [RD_W-1:0]   wb_r_o
);
    inst_u             inst;
    opcode_e           op;
    logic              is_r;
    logic              wait_rsv;
    logic              issue;
    logic [WORD_W-1:0] imm_ext;
    alu_op_e           alu_op;

    // the queue head is decoded in place and taken only when it issues.
    assign inst = inst_i;
    assign op   = inst.r.opcode;
    assign is_r = op inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR};

    // i format reads rd on the second port, so its destination is checked too.
    assign r0_o = inst.r.rs0;
    assign r1_o = is_r ? inst.r.rs1 : inst.i.rd;

    assign imm_ext  = {{(WORD_W - IMM_W){inst.i.imm[IMM_W-1]}}, inst.i.imm};
    assign wait_rsv = |reserved_i;
    assign issue    = v_i && !wait_rsv && !stall_i && !branch_i;
    assign stall_o  = stall_i || wait_rsv;

    assign w_reserve_o = issue && writes_reg(op);
    assign reserve_r_o = inst.r.rd;

    always_comb begin
        case (op)
            OP_ADD, OP_ADDI: alu_op = ALU_ADD;
            OP_SUB:          alu_op = ALU_SUB;
            OP_AND:          alu_op = ALU_AND;
            OP_OR:           alu_op = ALU_OR;
            OP_XOR:          alu_op = ALU_XOR;
            default:         alu_op = ALU_PASS;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            v_o <= 1'b0;
        end else if (branch_i) begin
            v_o <= 1'b0;
        end else if (!stall_i) begin
            v_o <= issue;
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            pc_o     <= pc_i;
            opr0_o   <= r_opr0_i;
            // addi takes its second alu operand from the immediate.
            opr1_o   <= (op == OP_ADDI) ? imm_ext : r_opr1_i;
            imm_o    <= imm_ext;
            alu_op_o <= alu_op;
            opcode_o <= op;
            wb_r_o   <= inst.r.rd;
        end
    end

endmodule

// ==== src/execute_unit.sv ====
`timescale 1ns/100ps

module execute_unit import cpu_pkg::*; #(
    parameter int WORD_W = WORD,
    parameter int ADDR_W = ADDR,
    parameter int RD_W   = W_RD
) (
    input  logic              clk,
    input  logic              rst_n_i,
    input  logic              v_i,
    input  logic              stall_i,
    input  logic [ADDR_W-1:0] pc_i,
    input  logic [WORD_W-1:0] opr0_i,
    input  logic [WORD_W-1:0] opr1_i,
    input  logic [WORD_W-1:0] imm_i,
    input  alu_op_e           alu_op_i,
    input  opcode_e           opcode_i,
    input  logic [RD_W-1:0]   wb_r_i,
    output logic              stall_o,
    output logic [ADDR_W-1:0] ldst_addr_o,
    output logic              ldst_write_o,
    output logic [WORD_W-1:0] ldst_data_o,
    input  logic [WORD_W-1:0] ldst_data_i,
    output logic              wb_o,
    output logic [RD_W-1:0]   wb_r_o,
    output logic [WORD_W-1:0] result_o,
    output logic              branch_o,
    output logic [ADDR_W-1:0] branch_addr_o,
    output logic              hlt_o
);
    localparam logic S_RUN  = 1'b0;
    localparam logic S_HALT = 1'b1;

    logic              state_q;
    logic              state_d;
    logic              active;
    logic              fire;
    logic              taken;
    logic [WORD_W-1:0] alu_res;
    logic [WORD_W-1:0] eff_addr;

    // active holds for the whole cycle, fire only on a cycle that completes.
    assign active = v_i && (state_q == S_RUN);
    assign fire   = active && !stall_i;

    always_comb begin
        case (alu_op_i)
            ALU_ADD: alu_res = opr0_i + opr1_i;
            ALU_SUB: alu_res = opr0_i - opr1_i;
            ALU_AND: alu_res = opr0_i & opr1_i;
            ALU_OR:  alu_res = opr0_i | opr1_i;
            ALU_XOR: alu_res = opr0_i ^ opr1_i;
            default: alu_res = opr0_i;
        endcase
    end

    assign eff_addr     = opr0_i + imm_i;
    assign ldst_addr_o  = eff_addr[ADDR_W-1:0];
    assign ldst_data_o  = opr1_i;
    assign ldst_write_o = active && (opcode_i == OP_ST);

    assign wb_o     = fire && writes_reg(opcode_i);
    assign wb_r_o   = wb_r_i;
    assign result_o = (opcode_i == OP_LD) ? ldst_data_i : alu_res;

    assign taken = ((opcode_i == OP_BEQ) && (opr0_i == opr1_i)) || (opcode_i == OP_JMP);
    assign branch_o = fire && taken;
    // beq is relative to the next pc.
    assign branch_addr_o = (opcode_i == OP_JMP) ? eff_addr[ADDR_W-1:0]
                                                : pc_i + 1'b1 + imm_i[ADDR_W-1:0];

    always_comb begin
        state_d = state_q;
        case (state_q)
            S_RUN: begin
                if (fire && opcode_i == OP_HLT) begin
                    state_d = S_HALT;
                end
            end
            default: state_d = S_HALT;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= S_RUN;
        end else begin
            state_q <= state_d;
        end
    end

    // once halted the pipeline behind stays frozen.
    assign stall_o = stall_i || (state_q == S_HALT);
    assign hlt_o   = (state_q == S_HALT);

endmodule

// ==== src/fetch_unit.sv ====
`timescale 1ns/100ps

module fetch_unit import cpu_pkg::*; #(
    parameter int WORD_W = WORD,
    parameter int ADDR_W = ADDR
) (
    input  logic              clk,
    input  logic              rst_n_i,
    input  logic              stall_i,
    input  logic              branch_i,
    input  logic [WORD_W-1:0] inst_i,
    input  logic [ADDR_W-1:0] pc_i,
    output logic              v_o,
    output logic [WORD_W-1:0] inst_o,
    output logic [ADDR_W-1:0] pc_o,
    output logic              stall_o
);
    logic v_q;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            v_q <= 1'b0;
        end else if (branch_i) begin
            v_q <= 1'b0;
        end else if (!stall_i) begin
            v_q <= 1'b1;
        end
    end

    // the held word stays put until the queue has room.
    always_ff @(posedge clk) begin
        if (!stall_i) begin
            inst_o <= inst_i;
            pc_o   <= pc_i;
        end
    end

    assign v_o     = v_q;
    // the pc must not advance past a word that could not be taken.
    assign stall_o = stall_i;

endmodule

// ==== src/inst_queue.sv ====
`timescale 1ns/100ps

module inst_queue import cpu_pkg::*; #(
    parameter int WORD_W = WORD,
    parameter int ADDR_W = ADDR,
    parameter int DEPTH  = QUEUE_DEPTH
) (
    input  logic              clk,
    input  logic              rst_n_i,
    input  logic              v_i,
    input  logic              stall_i,
    input  logic              branch_i,
    input  logic [WORD_W-1:0] inst_i,
    input  logic [ADDR_W-1:0] pc_i,
    output logic              v_o,
    output logic              stall_o,
    output logic [WORD_W-1:0] inst_o,
    output logic [ADDR_W-1:0] pc_o
);
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    logic [WORD_W-1:0] inst_q [DEPTH];
    logic [ADDR_W-1:0] pc_q [DEPTH];
    logic [PTR_W-1:0]  wr_ptr_q;
    logic [PTR_W-1:0]  rd_ptr_q;
    logic [PTR_W:0]    cnt_q;
    logic              push;
    logic              pop;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign stall_o = (cnt_q == (PTR_W + 1)'(DEPTH));
    assign v_o     = (cnt_q != '0);
    assign push    = v_i && !stall_o;
    assign pop     = v_o && !stall_i;
    assign inst_o  = inst_q[rd_ptr_q];
    assign pc_o    = pc_q[rd_ptr_q];

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            cnt_q    <= '0;
        end else if (branch_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            cnt_q    <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= next_ptr(wr_ptr_q);
            end
            if (pop) begin
                rd_ptr_q <= next_ptr(rd_ptr_q);
            end
            case ({push, pop})
                2'b10:   cnt_q <= cnt_q + 1'b1;
                2'b01:   cnt_q <= cnt_q - 1'b1;
                default: cnt_q <= cnt_q;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            inst_q[wr_ptr_q] <= inst_i;
            pc_q[wr_ptr_q]   <= pc_i;
        end
    end

endmodule

// ==== src/pc_counter.sv ====
`timescale 1ns/100ps

module pc_counter import cpu_pkg::*; #(
    parameter int ADDR_W = ADDR
) (
    input  logic              clk,
    input  logic              rst_n_i,
    input  logic              stall_i,
    input  logic              branch_i,
    input  logic [ADDR_W-1:0] branch_addr_i,
    output logic [ADDR_W-1:0] pc_o
);
    logic [ADDR_W-1:0] pc_q;

    // a branch redirects even while fetch is stalled.
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pc_q <= '0;
        end else if (branch_i) begin
            pc_q <= branch_addr_i;
        end else if (!stall_i) begin
            pc_q <= pc_q + 1'b1;
        end
    end

    assign pc_o = pc_q;

endmodule

// ==== src/reg_file.sv ====
`timescale 1ns/100ps

module reg_file import cpu_pkg::*; #(
    parameter int WORD_W = WORD,
    parameter int REG_N  = N_REG,
    parameter int RD_W   = W_RD
) (
    input  logic              clk,
    input  logic              rst_n_i,
    input  logic [RD_W-1:0]   r0_i,
    input  logic [RD_W-1:0]   r1_i,
    output logic [WORD_W-1:0] r_opr0_o,
    output logic [WORD_W-1:0] r_opr1_o,
    output logic [1:0]        reserved_o,
    input  logic              w_reserve_i,
    input  logic [RD_W-1:0]   reserve_r_i,
    input  logic              wb_i,
    input  logic [RD_W-1:0]   wb_r_i,
    input  logic [WORD_W-1:0] result_i
);
    logic [WORD_W-1:0] regs_q [REG_N];
    logic [REG_N-1:0]  rsv_q;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rsv_q <= '0;
            for (int i = 0; i < REG_N; i++) begin
                regs_q[i] <= '0;
            end
        end else begin
            // register 0 is hardwired to zero.
            if (wb_i && wb_r_i != '0) begin
                regs_q[wb_r_i] <= result_i;
            end
            if (wb_i) begin
                rsv_q[wb_r_i] <= 1'b0;
            end
            // a new reservation overrides a write-back to the same register.
            if (w_reserve_i && reserve_r_i != '0) begin
                rsv_q[reserve_r_i] <= 1'b1;
            end
        end
    end

    assign r_opr0_o   = regs_q[r0_i];
    assign r_opr1_o   = regs_q[r1_i];
    assign reserved_o = {rsv_q[r1_i], rsv_q[r0_i]};

endmodule

// ==== verif/tb_cpu_top.sv ====
`timescale 1ns/100ps

module tb_cpu_top import cpu_pkg::*; ();

    // 28 instructions, at most about 7 cycles each with stalls and waits, times ten.
    localparam int              MAX_CYCLES = 2000;
    localparam logic [ADDR-1:0] POISON     = 16'd99;

    logic              clk;
    logic              rst_n_i;
    logic              stall_i = 1'b0;
    logic [WORD-1:0]   inst_i;
    logic [ADDR-1:0]   inst_addr_o;
    logic [WORD-1:0]   ldst_data_i;
    logic [WORD-1:0]   ldst_data_o;
    logic [ADDR-1:0]   ldst_addr_o;
    logic              ldst_write_o;
    logic              hlt_o;
    logic              store_fire;

    logic [WORD-1:0]   rom [2**ADDR];
    logic [WORD-1:0]   ram [2**ADDR];
    logic [ADDR-1:0]   exp_addr [16];
    logic [WORD-1:0]   exp_data [16];
    logic [3:0]        n_exp = '0;
    logic [3:0]        st_cnt;
    logic [ADDR-1:0]   pgm_ptr = '0;
    integer            seed = 32'hdd32_20c9;
    int                cyc = 0;

    cpu_top #(.WORD_W(WORD), .ADDR_W(ADDR)) DUT (
        .clk(clk),
        .rst_n_i(rst_n_i),
        .stall_i(stall_i),
        .inst_i(inst_i),
        .inst_addr_o(inst_addr_o),
        .ldst_data_i(ldst_data_i),
        .ldst_data_o(ldst_data_o),
        .ldst_addr_o(ldst_addr_o),
        .ldst_write_o(ldst_write_o),
        .hlt_o(hlt_o)
    );

    // both memories answer in the same cycle.
    assign inst_i      = rom[inst_addr_o];
    assign ldst_data_i = ram[ldst_addr_o];
    assign store_fire  = ldst_write_o && !stall_i;

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("sim failed");
        $fatal(1, "stopping at the first failure");
    endtask

    function automatic logic [WORD-1:0] r_word(input opcode_e op, input logic [W_RD-1:0] rd,
                                               input logic [W_RD-1:0] rs0,
                                               input logic [W_RD-1:0] rs1);
        return {op, rd, rs0, rs1, 14'd0};
    endfunction

    // st and beq name their second register in rd.
    function automatic logic [WORD-1:0] i_word(input opcode_e op, input logic [W_RD-1:0] rd,
                                               input logic [W_RD-1:0] rs0, input int imm);
        return {op, rd, rs0, imm[W_IMM-1:0]};
    endfunction

    task automatic emit(input logic [WORD-1:0] w);
        rom[pgm_ptr] = w;
        pgm_ptr = pgm_ptr + ADDR'(1);
    endtask

    task automatic expect_store(input logic [ADDR-1:0] a, input logic [WORD-1:0] d);
        exp_addr[n_exp] = a;
        exp_data[n_exp] = d;
        n_exp = n_exp + 4'd1;
    endtask

    // every data word starts as a pattern of its own address.
    task automatic fill_ram();
        for (int a = 0; a < 2**ADDR; a++) begin
            ram[a[ADDR-1:0]] = {16'hd0d0, a[ADDR-1:0]};
        end
    endtask

    task automatic load_program();
        rom = '{default: '0};
        emit(i_word(OP_ADDI, 4'd1, 4'd0, 5));        // 0
        emit(i_word(OP_ADDI, 4'd2, 4'd1, -3));       // 1
        emit(r_word(OP_ADD, 4'd3, 4'd1, 4'd2));      // 2
        emit(r_word(OP_SUB, 4'd4, 4'd2, 4'd3));      // 3
        emit(r_word(OP_AND, 4'd5, 4'd3, 4'd4));      // 4
        emit(r_word(OP_OR, 4'd6, 4'd5, 4'd1));       // 5
        emit(r_word(OP_XOR, 4'd7, 4'd6, 4'd4));      // 6
        emit(i_word(OP_ST, 4'd4, 4'd0, 16));         // 7
        emit(i_word(OP_ST, 4'd5, 4'd0, 17));         // 8
        emit(i_word(OP_ST, 4'd6, 4'd0, 18));         // 9
        emit(i_word(OP_ST, 4'd7, 4'd0, 19));         // 10
        emit(i_word(OP_ADDI, 4'd8, 4'd0, -100));     // 11
        emit(i_word(OP_ST, 4'd8, 4'd1, 15));         // 12
        emit(i_word(OP_LD, 4'd9, 4'd1, 15));         // 13
        emit(i_word(OP_ST, 4'd9, 4'd0, 21));         // 14
        // r3 equals r6, so this goes to 18.
        emit(i_word(OP_BEQ, 4'd6, 4'd3, 2));         // 15
        emit(i_word(OP_ST, 4'd1, 4'd0, 99));         // 16
        emit(i_word(OP_ST, 4'd1, 4'd0, 99));         // 17
        emit(i_word(OP_BEQ, 4'd2, 4'd1, 3));         // 18
        emit(i_word(OP_ST, 4'd2, 4'd0, 22));         // 19
        emit(i_word(OP_ADDI, 4'd10, 4'd0, 24));      // 20
        emit(i_word(OP_JMP, 4'd0, 4'd10, 2));        // 21
        emit(i_word(OP_ST, 4'd1, 4'd0, 99));         // 22
        emit(i_word(OP_ST, 4'd1, 4'd0, 99));         // 23
        emit(i_word(OP_ST, 4'd1, 4'd0, 99));         // 24
        emit(i_word(OP_ST, 4'd1, 4'd0, 99));         // 25
        emit(i_word(OP_ST, 4'd3, 4'd0, 23));         // 26
        emit(r_word(OP_HLT, 4'd0, 4'd0, 4'd0));      // 27
        emit(i_word(OP_ST, 4'd1, 4'd0, 24));         // 28
    endtask

    // r1=5, r2=2, r3=7, r4=-5, r5=3, r6=7, r7=-5^7, r8=-100.
    task automatic load_expected();
        expect_store(16'd16, 32'hffff_fffb);
        expect_store(16'd17, 32'h0000_0003);
        expect_store(16'd18, 32'h0000_0007);
        expect_store(16'd19, 32'hffff_fffc);
        expect_store(16'd20, 32'hffff_ff9c);
        expect_store(16'd21, 32'hffff_ff9c);
        expect_store(16'd22, 32'h0000_0002);
        expect_store(16'd23, 32'h0000_0007);
    endtask

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // about one cycle in four the data side holds the core.
    always @(posedge clk) begin
        if (rst_n_i) begin
            stall_i <= (($random(seed) & 3) == 0);
        end
    end

    always @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            st_cnt <= '0;
        end else if (store_fire) begin
            ram[ldst_addr_o] <= ldst_data_o;
            st_cnt <= st_cnt + 4'd1;
        end
    end

    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (cyc >= MAX_CYCLES) begin
            fail_run($sformatf("timeout: the core did not halt within %0d cycles", MAX_CYCLES));
        end
    end

    assert property (@(posedge clk) !rst_n_i |-> (!ldst_write_o && !hlt_o && inst_addr_o == '0))
        else fail_run($sformatf("ERR %0t: outputs not cleared during reset", $time));

    assert property (@(posedge clk) disable iff (!rst_n_i) store_fire |-> st_cnt < n_exp)
        else fail_run("a store was accepted beyond the end of the expected list");

    assert property (@(posedge clk) disable iff (!rst_n_i)
        store_fire && st_cnt < n_exp |->
            ldst_addr_o == exp_addr[st_cnt] && ldst_data_o == exp_data[st_cnt])
        else fail_run($sformatf("ERR %0t: store %0d wrote %h to %h, expected %h to %h",
                                $time, $sampled(st_cnt), $sampled(ldst_data_o),
                                $sampled(ldst_addr_o), exp_data[$sampled(st_cnt)],
                                exp_addr[$sampled(st_cnt)]));

    assert property (@(posedge clk) disable iff (!rst_n_i) store_fire |-> ldst_addr_o != POISON)
        else fail_run("a skipped instruction stored to the poison address");

    assert property (@(posedge clk) disable iff (!rst_n_i)
        stall_i && ldst_write_o |=>
            ldst_write_o && $stable(ldst_addr_o) && $stable(ldst_data_o))
        else fail_run($sformatf("ERR %0t: data port changed while stalled", $time));

    assert property (@(posedge clk) disable iff (!rst_n_i) hlt_o |=> hlt_o)
        else fail_run("hlt_o fell after the core had halted");

    assert property (@(posedge clk) disable iff (!rst_n_i) hlt_o |-> !ldst_write_o)
        else fail_run("a store was presented after the core had halted");

    initial begin
        rst_n_i = 1'b0;
        fill_ram();
        load_program();
        load_expected();
        repeat (4) @(posedge clk);
        rst_n_i <= 1'b1;
        while (!hlt_o) begin
            @(posedge clk);
        end
        repeat (10) @(posedge clk);
        if (st_cnt != n_exp) begin
            fail_run($sformatf("only %0d of %0d expected stores were accepted", st_cnt, n_exp));
        end else begin
            $display("sim passed");
            $finish;
        end
    end

endmodule
